//--- Bender.yml
package:
  name: cache_memory

sources:
  - rtl/cache_pkg.sv
  - rtl/cache_mem_if.sv
  - rtl/cache_ram_1rw.sv
  - rtl/cache_access_ctrl.sv
  - rtl/cache_tag_array.sv
  - rtl/cache_data_array.sv
  - rtl/cache_memory.sv
  - target: test
    files:
      - tb/tb_cache_memory.sv

//--- rtl/cache_access_ctrl.sv
`default_nettype none

module cache_access_ctrl (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                fill_i,
  input  wire cache_pkg::idx_t     fill_idx_i,
  input  wire cache_pkg::way_vec_t fill_way_i,
  input  wire logic                wb_we_i,
  input  wire cache_pkg::idx_t     wb_idx_i,
  input  wire cache_pkg::way_vec_t wb_way_i,
  input  wire logic                lookup_i,
  input  wire cache_pkg::idx_t     lookup_idx_i,
  input  wire cache_pkg::way_vec_t victim_way_i,
  cache_mem_if.ctrl                mem,
  output      logic                rsp_valid_o
);

  // fill wins over write buffer, lookup gets the rest
  assign mem.fill_we = fill_i;
  assign mem.wb_we   = wb_we_i & ~fill_i;
  assign mem.ram_idx = fill_i  ? fill_idx_i :
                       wb_we_i ? wb_idx_i   : lookup_idx_i;
  assign mem.we_way  = fill_i  ? fill_way_i :
                       wb_we_i ? wb_way_i   : '0;

  ////////////////////
  // lookup pipeline
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      mem.rd_q  <= 1'b0;
      mem.latch <= 1'b0;
    end
    else
    begin
      mem.rd_q  <= lookup_i;  // RAM data out next cycle
      mem.latch <= mem.rd_q;  // results registered
    end
  end

  // context rides along with the RAM read
  always_ff @(posedge clk_i)
  begin
    mem.rd_idx_q <= lookup_idx_i;
    mem.victim_q <= victim_way_i;
  end

  assign rsp_valid_o = mem.latch;

  // single-port RAMs, no arbitration
  a_no_rw_overlap: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !((fill_i || wb_we_i) && lookup_i));
  a_fill_way_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fill_i |-> $onehot(fill_way_i));
  a_wb_way_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_we_i |-> $onehot(wb_way_i));

endmodule

`default_nettype wire

//--- rtl/cache_data_array.sv
`default_nettype none

module cache_data_array (
  input  wire logic                clk_i,
  cache_mem_if.array               mem,
  input  wire cache_pkg::line_t    fill_line_i,
  input  wire cache_pkg::offs_t    wb_offs_i,
  input  wire cache_pkg::word_be_t wb_be_i,
  input  wire cache_pkg::word_t    wb_data_i,
  input  wire cache_pkg::way_vec_t ways_hit_i,  // combinational, from tag array
  output      cache_pkg::line_t    line_o,
  output      cache_pkg::line_t    evict_line_o
);

  cache_pkg::line_t    dat_in;
  cache_pkg::line_be_t dat_be;
  cache_pkg::line_be_t wb_line_be;
  cache_pkg::line_t    dat_rd [cache_pkg::WAYS];
  cache_pkg::line_t    hit_line, victim_line;

  // word copied to every slot, lanes pick the real one
  assign wb_line_be = cache_pkg::line_be_t'(wb_be_i) << (wb_offs_i * (cache_pkg::XLEN / 8));

  assign dat_in = mem.fill_we ? fill_line_i : {cache_pkg::WORDS{wb_data_i}};
  assign dat_be = mem.fill_we ? '1          : wb_line_be;  // fill writes whole line

  for (genvar w = 0; w < cache_pkg::WAYS; w++)
  begin : gen_way
    cache_ram_1rw #(
      .DEPTH ( cache_pkg::SETS     ),
      .WIDTH ( cache_pkg::BLK_BITS )
    ) data_ram_i (
      .clk_i  ( clk_i                                        ),
      .addr_i ( mem.ram_idx                                  ),
      .we_i   ( (mem.fill_we | mem.wb_we) & mem.we_way[w]    ),
      .be_i   ( dat_be                                       ),
      .din_i  ( dat_in                                       ),
      .dout_o ( dat_rd[w]                                    )
    );
  end

  ////////////////////
  // output muxes
  ////////////////////

  always_comb
  begin
    hit_line    = '0;
    victim_line = '0;
    for (int w = 0; w < cache_pkg::WAYS; w++)
    begin
      hit_line    |= dat_rd[w] & {cache_pkg::BLK_BITS{ways_hit_i[w]}};
      victim_line |= dat_rd[w] & {cache_pkg::BLK_BITS{mem.victim_q[w]}};
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (mem.rd_q)
    begin
      line_o       <= hit_line;     // zero on a miss
      evict_line_o <= victim_line;
    end
  end

  // AND-OR mux breaks if a line sits in two ways
  a_hit_onehot0: assert property (@(posedge clk_i)
    mem.rd_q |-> $onehot0(ways_hit_i));

endmodule

`default_nettype wire

//--- rtl/cache_mem_if.sv
`default_nettype none

// access schedule, shared by tag and data arrays
interface cache_mem_if;

  cache_pkg::idx_t     ram_idx;   // address into every RAM
  logic                fill_we;   // line fill this cycle
  logic                wb_we;     // write-buffer merge this cycle
  cache_pkg::way_vec_t we_way;    // ways written, zero when idle
  logic                rd_q;      // RAM outputs hold lookup data
  cache_pkg::idx_t     rd_idx_q;  // index of that lookup
  cache_pkg::way_vec_t victim_q;  // eviction way of that lookup
  logic                latch;     // results registered, rsp valid

  modport ctrl (
    output ram_idx, fill_we, wb_we, we_way,
    output rd_q, rd_idx_q, victim_q, latch
  );

  // results load on rd_q, the same edge that raises latch
  modport array (
    input ram_idx, fill_we, wb_we, we_way,
    input rd_q, rd_idx_q, victim_q
  );

endinterface

`default_nettype wire

//--- rtl/cache_memory.sv
`default_nettype none

module cache_memory (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  // line fill
  input  wire logic                fill_i,
  input  wire cache_pkg::idx_t     fill_idx_i,
  input  wire cache_pkg::tag_t     fill_tag_i,
  input  wire cache_pkg::way_vec_t fill_way_i,
  input  wire cache_pkg::line_t    fill_line_i,
  input  wire logic                fill_dirty_i,
  // write-buffer merge
  input  wire logic                wb_we_i,
  input  wire cache_pkg::idx_t     wb_idx_i,
  input  wire cache_pkg::offs_t    wb_offs_i,
  input  wire cache_pkg::word_be_t wb_be_i,
  input  wire cache_pkg::word_t    wb_data_i,
  input  wire cache_pkg::way_vec_t wb_way_i,
  // lookup, invalidate
  input  wire logic                lookup_i,
  input  wire cache_pkg::idx_t     lookup_idx_i,
  input  wire cache_pkg::tag_t     lookup_tag_i,
  input  wire cache_pkg::way_vec_t victim_way_i,
  input  wire logic                inv_all_i,
  // result, two cycles after lookup
  output      logic                rsp_valid_o,
  output      logic                hit_o,
  output      cache_pkg::way_vec_t ways_hit_o,
  output      cache_pkg::line_t    line_o,
  output      logic                cache_dirty_o,
  output      cache_pkg::tag_t     evict_tag_o,
  output      cache_pkg::line_t    evict_line_o,
  output      logic                evict_dirty_o
);

  cache_mem_if mem_if ();

  cache_pkg::way_vec_t ways_hit_comb;  // tag compare, feeds data mux

  cache_access_ctrl access_ctrl_i (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .fill_i       ( fill_i       ),
    .fill_idx_i   ( fill_idx_i   ),
    .fill_way_i   ( fill_way_i   ),
    .wb_we_i      ( wb_we_i      ),
    .wb_idx_i     ( wb_idx_i     ),
    .wb_way_i     ( wb_way_i     ),
    .lookup_i     ( lookup_i     ),
    .lookup_idx_i ( lookup_idx_i ),
    .victim_way_i ( victim_way_i ),
    .mem          ( mem_if.ctrl  ),
    .rsp_valid_o  ( rsp_valid_o  )
  );

  cache_tag_array tag_array_i (
    .clk_i           ( clk_i         ),
    .rst_ni          ( rst_ni        ),
    .mem             ( mem_if.array  ),
    .fill_tag_i      ( fill_tag_i    ),
    .fill_dirty_i    ( fill_dirty_i  ),
    .lookup_tag_i    ( lookup_tag_i  ),
    .inv_all_i       ( inv_all_i     ),
    .hit_o           ( hit_o         ),
    .ways_hit_o      ( ways_hit_o    ),
    .ways_hit_comb_o ( ways_hit_comb ),
    .cache_dirty_o   ( cache_dirty_o ),
    .evict_tag_o     ( evict_tag_o   ),
    .evict_dirty_o   ( evict_dirty_o )
  );

  cache_data_array data_array_i (
    .clk_i        ( clk_i         ),
    .mem          ( mem_if.array  ),
    .fill_line_i  ( fill_line_i   ),
    .wb_offs_i    ( wb_offs_i     ),
    .wb_be_i      ( wb_be_i       ),
    .wb_data_i    ( wb_data_i     ),
    .ways_hit_i   ( ways_hit_comb ),
    .line_o       ( line_o        ),
    .evict_line_o ( evict_line_o  )
  );

endmodule

`default_nettype wire

//--- rtl/cache_pkg.sv
`default_nettype none

package cache_pkg;

  ////////////////////
  // geometry
  ////////////////////

  localparam int XLEN      = 32;  // data word
  localparam int PLEN      = 34;  // physical address
  localparam int WAYS      = 2;
  localparam int SETS      = 16;
  localparam int BLK_BITS  = 64;  // one cache line
  localparam int WORDS     = BLK_BITS / XLEN;
  localparam int IDX_BITS  = $clog2(SETS);
  localparam int OFFS_BITS = $clog2(WORDS);
  // address minus index minus byte offset within the line
  localparam int TAG_BITS  = PLEN - IDX_BITS - 3;

  ////////////////////
  // vector types
  ////////////////////

  typedef logic [IDX_BITS-1:0]   idx_t;      // set index
  typedef logic [TAG_BITS-1:0]   tag_t;      // address tag
  typedef logic [BLK_BITS-1:0]   line_t;     // whole line
  typedef logic [BLK_BITS/8-1:0] line_be_t;  // byte lanes of a line
  typedef logic [XLEN-1:0]       word_t;
  typedef logic [XLEN/8-1:0]     word_be_t;
  typedef logic [OFFS_BITS-1:0]  offs_t;     // word within line
  typedef logic [WAYS-1:0]       way_vec_t;  // one bit per way

endpackage

`default_nettype wire

//--- rtl/cache_ram_1rw.sv
`default_nettype none

module cache_ram_1rw #(
  parameter int DEPTH = 16,
  parameter int WIDTH = 32
) (
  input  wire logic                       clk_i,
  input  wire logic [$clog2(DEPTH)-1:0]   addr_i,
  input  wire logic                       we_i,
  input  wire logic [(WIDTH+7)/8-1:0]     be_i,    // last lane may be partial
  input  wire logic [WIDTH-1:0]           din_i,
  output      logic [WIDTH-1:0]           dout_o
);

  logic [WIDTH-1:0] mem_q [DEPTH];

  // write per byte lane, read otherwise
  always_ff @(posedge clk_i)
  begin
    if (we_i)
    begin
      for (int b = 0; b < WIDTH; b++)
      begin
        if (be_i[b/8])
          mem_q[addr_i][b] <= din_i[b];
      end
    end
    else
    begin
      dout_o <= mem_q[addr_i];  // held through write cycles
    end
  end

endmodule

`default_nettype wire

//--- rtl/cache_tag_array.sv
`default_nettype none

module cache_tag_array (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  cache_mem_if.array               mem,
  input  wire cache_pkg::tag_t     fill_tag_i,
  input  wire logic                fill_dirty_i,
  input  wire cache_pkg::tag_t     lookup_tag_i,
  input  wire logic                inv_all_i,
  output      logic                hit_o,
  output      cache_pkg::way_vec_t ways_hit_o,
  output      cache_pkg::way_vec_t ways_hit_comb_o,  // to data array mux
  output      logic                cache_dirty_o,
  output      cache_pkg::tag_t     evict_tag_o,
  output      logic                evict_dirty_o
);

  logic [cache_pkg::WAYS-1:0][cache_pkg::SETS-1:0] valid_q, dirty_q;

  cache_pkg::tag_t     lookup_tag_q;               // aligned with rd_q
  cache_pkg::tag_t     tag_rd [cache_pkg::WAYS];   // RAM outputs
  cache_pkg::way_vec_t way_dirty;
  cache_pkg::way_vec_t hit_comb;
  cache_pkg::tag_t     victim_tag;

  always_ff @(posedge clk_i)
    lookup_tag_q <= lookup_tag_i;

  ////////////////////
  // per-way tags
  ////////////////////

  for (genvar w = 0; w < cache_pkg::WAYS; w++)
  begin : gen_way
    cache_ram_1rw #(
      .DEPTH ( cache_pkg::SETS     ),
      .WIDTH ( cache_pkg::TAG_BITS )
    ) tag_ram_i (
      .clk_i  ( clk_i                        ),
      .addr_i ( mem.ram_idx                  ),
      .we_i   ( mem.fill_we & mem.we_way[w]  ),  // only fills touch the tag
      .be_i   ( '1                           ),
      .din_i  ( fill_tag_i                   ),
      .dout_o ( tag_rd[w]                    )
    );

    assign way_dirty[w] = dirty_q[w][mem.rd_idx_q];
    assign hit_comb[w]  = valid_q[w][mem.rd_idx_q] & (tag_rd[w] == lookup_tag_q);
  end

  assign ways_hit_comb_o = hit_comb;

  // valid and dirty live in flops so invalidate is one edge
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      valid_q <= '0;
      dirty_q <= '0;
    end
    else if (inv_all_i)
    begin
      valid_q <= '0;
      dirty_q <= '0;
    end
    else
    begin
      for (int w = 0; w < cache_pkg::WAYS; w++)
      begin
        if (mem.fill_we && mem.we_way[w])
        begin
          valid_q[w][mem.ram_idx] <= 1'b1;
          dirty_q[w][mem.ram_idx] <= fill_dirty_i;  // line may arrive dirty
        end
        else if (mem.wb_we && mem.we_way[w])
          dirty_q[w][mem.ram_idx] <= 1'b1;
      end
    end
  end

  // victim tag, AND-OR over a one-hot way
  always_comb
  begin
    victim_tag = '0;
    for (int w = 0; w < cache_pkg::WAYS; w++)
      victim_tag |= tag_rd[w] & {cache_pkg::TAG_BITS{mem.victim_q[w]}};
  end

  ////////////////////
  // results
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      hit_o         <= 1'b0;
      ways_hit_o    <= '0;
      cache_dirty_o <= 1'b0;
    end
    else if (mem.rd_q)
    begin
      hit_o         <= |hit_comb;
      ways_hit_o    <= hit_comb;
      cache_dirty_o <= |(valid_q & dirty_q);  // any dirty line anywhere
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (mem.rd_q)
    begin
      evict_tag_o   <= victim_tag;
      evict_dirty_o <= |(way_dirty & mem.victim_q);
    end
  end

endmodule

`default_nettype wire

//--- tb/tb_cache_memory.sv
`default_nettype none

module tb_cache_memory;

  typedef struct packed {
    logic                hit;
    cache_pkg::way_vec_t ways;
    cache_pkg::line_t    line;
    logic                cdirty;  // any valid dirty line
    logic                evalid;  // victim way holds a line
    cache_pkg::tag_t     etag;
    cache_pkg::line_t    eline;
    logic                edirty;
  } rsp_t;

  logic                clk_i = 1'b0;
  logic                rst_ni;
  logic                fill_i, fill_dirty_i, wb_we_i, lookup_i, inv_all_i;
  cache_pkg::idx_t     fill_idx_i, wb_idx_i, lookup_idx_i;
  cache_pkg::tag_t     fill_tag_i, lookup_tag_i;
  cache_pkg::way_vec_t fill_way_i, wb_way_i, victim_way_i;
  cache_pkg::line_t    fill_line_i;
  cache_pkg::offs_t    wb_offs_i;
  cache_pkg::word_be_t wb_be_i;
  cache_pkg::word_t    wb_data_i;
  logic                rsp_valid_o, hit_o, cache_dirty_o, evict_dirty_o;
  cache_pkg::way_vec_t ways_hit_o;
  cache_pkg::line_t    line_o, evict_line_o;
  cache_pkg::tag_t     evict_tag_o;

  // reference model with one entry per way and set
  cache_pkg::tag_t  m_tag   [cache_pkg::WAYS][cache_pkg::SETS];
  cache_pkg::line_t m_line  [cache_pkg::WAYS][cache_pkg::SETS];
  logic             m_valid [cache_pkg::WAYS][cache_pkg::SETS];
  logic             m_dirty [cache_pkg::WAYS][cache_pkg::SETS];

  rsp_t exp_q [$];  // one entry per lookup in flight
  rsp_t exp_r;      // head entry loaded one cycle before its response
  logic look_d;
  int   issued = 0;
  int   answered;

  always #5 clk_i = ~clk_i;

  cache_memory cache_memory_i (.*);

  task automatic abort_run(input string why);
    $display("%s (time %0t)", why, $time);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string what);
    $display("FAILED at time %0t: %s", $time, what);
    $display("Errors found");
    $fatal(1);
  endtask

  ////////////////////
  // response checks
  ////////////////////

  always @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      look_d   <= 1'b0;
      answered <= 0;
    end
    else
    begin
      look_d <= lookup_i;
      if (rsp_valid_o)
        answered <= answered + 1;
      if (look_d)  // RAM read done and result registers next edge
        exp_r <= exp_q.pop_front();
    end
  end

  a_reset_idle: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !rsp_valid_o && !hit_o && !cache_dirty_o)
    else report_mismatch("outputs not idle after reset");
  a_rsp_timing: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o == $past(lookup_i, 2))
    else report_mismatch("rsp_valid_o not exactly two cycles after lookup_i");
  a_rsp_hit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o |-> hit_o == exp_r.hit && ways_hit_o == exp_r.ways)
    else report_mismatch("hit_o or ways_hit_o wrong");
  a_rsp_line: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o && exp_r.hit |-> line_o == exp_r.line)
    else report_mismatch("line_o differs from hit line");
  a_rsp_dirty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o |-> cache_dirty_o == exp_r.cdirty)
    else report_mismatch("cache_dirty_o wrong");
  a_evict_dirty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o |-> evict_dirty_o == exp_r.edirty)
    else report_mismatch("evict_dirty_o wrong");
  a_evict_line: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o && exp_r.evalid |-> evict_tag_o == exp_r.etag && evict_line_o == exp_r.eline)
    else report_mismatch("evict_tag_o or evict_line_o wrong");

  ////////////////////
  // stimulus tasks
  ////////////////////

  task automatic next_cycle();
    @(posedge clk_i);
    #1;  // inputs change just after the edge
  endtask

  task automatic fill_line(input cache_pkg::idx_t idx, input int w, input cache_pkg::tag_t tag,
                           input cache_pkg::line_t line, input logic dirty);
    fill_i        = 1'b1;
    fill_idx_i    = idx;
    fill_way_i    = cache_pkg::way_vec_t'(1 << w);
    fill_tag_i    = tag;
    fill_line_i   = line;
    fill_dirty_i  = dirty;
    m_tag[w][idx]   = tag;
    m_line[w][idx]  = line;
    m_valid[w][idx] = 1'b1;
    m_dirty[w][idx] = dirty;  // taken from the bus
    next_cycle();
    fill_i = 1'b0;
  endtask

  task automatic merge_word(input cache_pkg::idx_t idx, input int w, input cache_pkg::offs_t offs,
                            input cache_pkg::word_be_t be, input cache_pkg::word_t data);
    wb_we_i   = 1'b1;
    wb_idx_i  = idx;
    wb_way_i  = cache_pkg::way_vec_t'(1 << w);
    wb_offs_i = offs;
    wb_be_i   = be;
    wb_data_i = data;
    for (int b = 0; b < cache_pkg::XLEN / 8; b++)
    begin
      if (be[b])  // only enabled bytes of the addressed word
        m_line[w][idx][offs * cache_pkg::XLEN + b * 8 +: 8] = data[b * 8 +: 8];
    end
    m_dirty[w][idx] = 1'b1;
    next_cycle();
    wb_we_i = 1'b0;
  endtask

  // drives one lookup cycle and leaves the clock to the caller
  task automatic issue_lookup(input cache_pkg::idx_t idx, input cache_pkg::tag_t tag,
                              input int vw);
    rsp_t e;
    e = '0;
    for (int w = 0; w < cache_pkg::WAYS; w++)
    begin
      if (m_valid[w][idx] && m_tag[w][idx] == tag)
      begin
        e.ways[w] = 1'b1;
        e.line    = m_line[w][idx];
      end
      for (int s = 0; s < cache_pkg::SETS; s++)
        e.cdirty |= m_valid[w][s] & m_dirty[w][s];
    end
    e.hit    = |e.ways;
    e.evalid = m_valid[vw][idx];
    e.etag   = m_tag[vw][idx];
    e.eline  = m_line[vw][idx];
    e.edirty = m_dirty[vw][idx];  // flag kept even for an invalid line
    exp_q.push_back(e);
    issued++;
    lookup_i     = 1'b1;
    lookup_idx_i = idx;
    lookup_tag_i = tag;
    victim_way_i = cache_pkg::way_vec_t'(1 << vw);
  endtask

  task automatic wait_responses();
    int cycles;
    cycles = 0;
    lookup_i = 1'b0;
    while (answered != issued)
    begin
      if (cycles == 10)
        abort_run("timeout waiting for lookup responses");
      else
      begin
        next_cycle();
        cycles++;
      end
    end
  endtask

  task automatic lookup_once(input cache_pkg::idx_t idx, input cache_pkg::tag_t tag, input int vw);
    issue_lookup(idx, tag, vw);
    next_cycle();
    wait_responses();
  endtask

  ////////////////////
  // test sequence
  ////////////////////

  initial
  begin
    cache_pkg::tag_t tag;
    void'($urandom(32'hd056));
    {rst_ni, fill_i, fill_dirty_i, wb_we_i, lookup_i, inv_all_i} = '0;
    {fill_idx_i, wb_idx_i, lookup_idx_i, fill_tag_i, lookup_tag_i} = '0;
    {fill_way_i, wb_way_i, victim_way_i, fill_line_i} = '0;
    {wb_offs_i, wb_be_i, wb_data_i} = '0;
    for (int w = 0; w < cache_pkg::WAYS; w++)
    begin
      for (int s = 0; s < cache_pkg::SETS; s++)
      begin
        m_tag[w][s]   = '0;
        m_line[w][s]  = '0;
        m_valid[w][s] = 1'b0;
        m_dirty[w][s] = 1'b0;
      end
    end
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // every set of the empty cache misses on back-to-back lookups
    for (int i = 0; i < cache_pkg::SETS; i++)
    begin
      issue_lookup(cache_pkg::idx_t'(i), cache_pkg::tag_t'($urandom()), i % 2);
      next_cycle();
    end
    wait_responses();

    // clean fills hit on their own tag and miss on another
    for (int i = 0; i < 8; i++)
    begin
      tag = cache_pkg::tag_t'($urandom());
      fill_line(cache_pkg::idx_t'(i), i % 2, tag, {$urandom(), $urandom()}, 1'b0);
      lookup_once(cache_pkg::idx_t'(i), tag, 1 - i % 2);
      lookup_once(cache_pkg::idx_t'(i), tag ^ 1, i % 2);  // miss with a resident victim
    end

    // byte-enabled merges into resident lines
    for (int i = 0; i < 8; i++)
    begin
      merge_word(cache_pkg::idx_t'(i), i % 2, cache_pkg::offs_t'($urandom()),
                 cache_pkg::word_be_t'($urandom()), $urandom());
      lookup_once(cache_pkg::idx_t'(i), m_tag[i % 2][i], i % 2);
    end

    // both ways filled with random dirty flags and the victim read on hit and miss
    for (int i = 8; i < 12; i++)
    begin
      for (int w = 0; w < cache_pkg::WAYS; w++)
        fill_line(cache_pkg::idx_t'(i), w, cache_pkg::tag_t'($urandom()),
                  {$urandom(), $urandom()}, ($urandom() % 2) == 1);
      lookup_once(cache_pkg::idx_t'(i), m_tag[0][i], 1);
      lookup_once(cache_pkg::idx_t'(i), ~m_tag[1][i], 0);
    end

    // back-to-back hits on different sets
    for (int i = 0; i < 12; i++)
    begin
      issue_lookup(cache_pkg::idx_t'(i), m_tag[i % 2][i], (i + 1) % 2);
      next_cycle();
    end
    wait_responses();

    // earlier hits miss after invalidate all
    inv_all_i = 1'b1;
    for (int w = 0; w < cache_pkg::WAYS; w++)
    begin
      for (int s = 0; s < cache_pkg::SETS; s++)
      begin
        m_valid[w][s] = 1'b0;
        m_dirty[w][s] = 1'b0;
      end
    end
    next_cycle();
    inv_all_i = 1'b0;
    for (int i = 0; i < cache_pkg::SETS; i++)
    begin
      issue_lookup(cache_pkg::idx_t'(i), m_tag[i % 2][i], i % 2);
      next_cycle();
    end
    wait_responses();

    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
rtl/cache_pkg.sv
rtl/cache_mem_if.sv
rtl/cache_ram_1rw.sv
rtl/cache_access_ctrl.sv
rtl/cache_tag_array.sv
rtl/cache_data_array.sv
rtl/cache_memory.sv
tb/tb_cache_memory.sv
